// File: issue2_pkg.sv
// Issue2 lane types
`default_nettype none

package issue2_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic words
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;      // RV32 data word
  typedef logic [4:0]  reg_addr_t;  // Register index

  // ALU operator encoding
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9
  } alu_op_e;

  localparam logic [6:0] OPCODE_OP    = 7'h33;  // Register-register
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;  // Register-immediate

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

  //////////////////////////////////////////////////////////////////////
  // Instruction word views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
  } instr_u;

  //////////////////////////////////////////////////////////////////////
  // Lane records
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic   valid;
    instr_u word;
  } pfb_word_t;  // 33 bits

  typedef struct packed {
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
  } rf_read_t;  // 10 bits

  typedef struct packed {
    logic      valid;      // Legal instruction present
    alu_op_e   alu_op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    reg_addr_t waddr;
    logic      we;
  } id_ex_t;  // 75 bits

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;
  } rf_write_t;  // 38 bits

endpackage

`default_nettype wire

// File: issue2_alu.sv
// Issue2 integer ALU
`timescale 1ns/100ps
`default_nettype none

module issue2_alu import issue2_pkg::*; (
  input  alu_op_e op_i,
  input  xlen_t   a_i,
  input  xlen_t   b_i,
  output xlen_t   result_o
);

  logic [4:0] shamt;  // Low five bits of b
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = xlen_t'($signed(a_i) >>> shamt);  // Sign fill
      ALU_SLT:  result_o = {31'b0, lt_signed};
      ALU_SLTU: result_o = {31'b0, lt_unsigned};
      default:  result_o = '0;                              // Unused codes
    endcase
  end

endmodule

`default_nettype wire

// File: issue2_decoder.sv
// Issue2 instruction decoder
`timescale 1ns/100ps
`default_nettype none

module issue2_decoder import issue2_pkg::*; (
  input  instr_u    instr_i,
  output alu_op_e   alu_op_o,
  output logic      use_imm_o,  // Operand b from the immediate
  output xlen_t     imm_o,
  output rf_read_t  rs_o,
  output reg_addr_t waddr_o,
  output logic      we_o,       // Writes a nonzero register
  output logic      illegal_o
);

  logic [2:0] f3;
  logic       f7_base;
  logic       f7_alt;

  assign f3      = instr_i.r_view.funct3;
  assign f7_base = (instr_i.r_view.funct7 == F7_BASE);
  assign f7_alt  = (instr_i.r_view.funct7 == F7_ALT);

  always_comb begin
    alu_op_o  = ALU_ADD;
    use_imm_o = 1'b0;
    imm_o     = {{20{instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};  // I-type sign extend
    illegal_o = 1'b0;

    case (f3)                                  // Common funct3 mapping
      F3_ADD_SUB: alu_op_o = ALU_ADD;
      F3_SLL:     alu_op_o = ALU_SLL;
      F3_SLT:     alu_op_o = ALU_SLT;
      F3_SLTU:    alu_op_o = ALU_SLTU;
      F3_XOR:     alu_op_o = ALU_XOR;
      F3_SRL_SRA: alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_op_o = ALU_OR;
      default:    alu_op_o = ALU_AND;
    endcase

    case (instr_i.r_view.opcode)
      OPCODE_OP: begin
        if (f3 == F3_ADD_SUB && f7_alt) begin
          alu_op_o = ALU_SUB;
        end
        // Alternate funct7 only exists for SUB and SRA
        illegal_o = !(f7_base || (f7_alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)));
      end
      OPCODE_OPIMM: begin
        use_imm_o = 1'b1;
        if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
          imm_o = {27'b0, instr_i.r_view.rs2};  // Shift amount sits in rs2 field
        end
        if (f3 == F3_SLL) begin
          illegal_o = !f7_base;
        end else if (f3 == F3_SRL_SRA) begin
          illegal_o = !(f7_base || f7_alt);
        end
      end
      default: illegal_o = 1'b1;               // Not an integer ALU op
    endcase
  end

  assign rs_o.rs1_addr = instr_i.r_view.rs1;
  assign rs_o.rs2_addr = instr_i.r_view.rs2;
  assign waddr_o       = instr_i.r_view.rd;
  assign we_o          = !illegal_o && (instr_i.r_view.rd != '0);  // x0 never written

endmodule

`default_nettype wire

// File: issue2_fetcher.sv
// Issue2 instruction fetcher
`timescale 1ns/100ps
`default_nettype none

module issue2_fetcher import issue2_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      di_en_i,               // Dual issue enabled
  input  pfb_word_t pfb_i,                 // Prefetch buffer head
  input  logic      pi_unusual_prevent_i,  // Primary lane blocks new fetches
  input  logic      id_advance_i,          // ID consumes the held word
  input  logic      kill_i,
  output logic      pfb_pop_o,
  output instr_u    instr_o,
  output logic      instr_valid_o
);

  logic   valid_q;  // Slot occupied
  instr_u instr_q;  // Candidate word
  logic   pop;

  // Take a new word when the slot frees up this cycle
  // Held off during a flush so no word is taken from a stale buffer
  assign pop = di_en_i && pfb_i.valid && !pi_unusual_prevent_i && !kill_i
               && (!valid_q || id_advance_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;        // Flush the candidate
    end else if (pop) begin
      valid_q <= 1'b1;        // Refill
    end else if (id_advance_i) begin
      valid_q <= 1'b0;        // Consumed with nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      instr_q <= pfb_i.word;  // Capture at the pop edge
    end
  end

  assign pfb_pop_o     = pop;
  assign instr_o       = instr_q;
  assign instr_valid_o = valid_q;

endmodule

`default_nettype wire

// File: issue2_id_stage.sv
// Issue2 ID stage
`timescale 1ns/100ps
`default_nettype none

module issue2_id_stage import issue2_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  instr_u    instr_i,
  input  logic      instr_valid_i,
  input  xlen_t     rf_rdata_a_i,   // Same-cycle read data
  input  xlen_t     rf_rdata_b_i,
  input  rf_write_t ex_fwd_i,       // EX result for bypass
  input  logic      ex_ready_i,
  input  logic      pi_id_ready_i,
  input  logic      kill_i,
  output rf_read_t  rf_read_o,
  output logic      id_advance_o,
  output id_ex_t    id_ex_o,
  output logic      illegal_o
);

  alu_op_e   dec_alu_op;
  logic      dec_use_imm;
  xlen_t     dec_imm;
  rf_read_t  dec_rs;
  reg_addr_t dec_waddr;
  logic      dec_we;
  logic      dec_illegal;
  logic      fwd_a;
  logic      fwd_b;
  xlen_t     operand_a;
  xlen_t     operand_b_reg;
  id_ex_t    id_ex_d;
  id_ex_t    id_ex_q;

  issue2_decoder u_decoder (
    .instr_i   (instr_i),
    .alu_op_o  (dec_alu_op),
    .use_imm_o (dec_use_imm),
    .imm_o     (dec_imm),
    .rs_o      (dec_rs),
    .waddr_o   (dec_waddr),
    .we_o      (dec_we),
    .illegal_o (dec_illegal)
  );

  assign rf_read_o    = dec_rs;
  assign id_advance_o = pi_id_ready_i && ex_ready_i;  // Lane follows the primary issue

  //////////////////////////////////////////////////////////////////////
  // Operand bypass from EX
  //////////////////////////////////////////////////////////////////////

  assign fwd_a = ex_fwd_i.we && (ex_fwd_i.waddr == dec_rs.rs1_addr) && (dec_rs.rs1_addr != '0);
  assign fwd_b = ex_fwd_i.we && (ex_fwd_i.waddr == dec_rs.rs2_addr) && (dec_rs.rs2_addr != '0);

  assign operand_a     = fwd_a ? ex_fwd_i.wdata : rf_rdata_a_i;
  assign operand_b_reg = fwd_b ? ex_fwd_i.wdata : rf_rdata_b_i;

  always_comb begin
    id_ex_d.valid     = instr_valid_i && !dec_illegal;  // Illegal words become bubbles
    id_ex_d.alu_op    = dec_alu_op;
    id_ex_d.operand_a = operand_a;
    id_ex_d.operand_b = dec_use_imm ? dec_imm : operand_b_reg;
    id_ex_d.waddr     = dec_waddr;
    id_ex_d.we        = dec_we;
  end

  // ID/EX register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q.valid <= 1'b0;
    end else if (kill_i) begin
      id_ex_q.valid <= 1'b0;           // Flush in-flight op
    end else if (id_advance_o) begin
      id_ex_q <= id_ex_d;
    end else if (ex_ready_i) begin
      id_ex_q.valid <= 1'b0;           // EX drained while ID held back
    end
  end

  assign id_ex_o   = id_ex_q;
  assign illegal_o = instr_valid_i && dec_illegal && id_advance_o && !kill_i;  // One pulse

endmodule

`default_nettype wire

// File: issue2_ex_stage.sv
// Issue2 EX stage
`timescale 1ns/100ps
`default_nettype none

module issue2_ex_stage import issue2_pkg::*; (
  input  id_ex_t    id_ex_i,        // From ID/EX register
  input  logic      pi_ex_ready_i,  // Primary lane EX ready
  input  logic      kill_i,
  output logic      ex_ready_o,
  output rf_write_t write_o         // Register file write and bypass
);

  xlen_t alu_result;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  issue2_alu u_alu (
    .op_i     (id_ex_i.alu_op),
    .a_i      (id_ex_i.operand_a),
    .b_i      (id_ex_i.operand_b),
    .result_o (alu_result)
  );

  // Single-cycle ALU so EX is ready whenever the primary EX is
  assign ex_ready_o = pi_ex_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Commit only once per record and never under a flush
  assign write_o.we    = id_ex_i.valid && id_ex_i.we && pi_ex_ready_i && !kill_i;
  assign write_o.waddr = id_ex_i.waddr;
  assign write_o.wdata = alu_result;

endmodule

`default_nettype wire

// File: issue2.sv
// Issue2 lane top
`timescale 1ns/100ps
`default_nettype none

module issue2 import issue2_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      di_en_i,               // Dual issue enabled
  input  pfb_word_t pfb_i,
  output logic      pfb_pop_o,
  output rf_read_t  rf_read_o,
  input  xlen_t     rf_rdata_a_i,
  input  xlen_t     rf_rdata_b_i,
  output rf_write_t rf_write_o,
  input  logic      pi_id_ready_i,         // Primary lane ready levels
  input  logic      pi_ex_ready_i,
  input  logic      pi_branch_taken_i,     // Primary branch in EX
  input  logic      pi_unusual_kill_i,
  input  logic      pi_unusual_prevent_i,
  output logic      i2_illegal_o
);

  logic      kill;
  logic      id_advance;   // Combined stall
  logic      ex_ready;
  instr_u    if_instr;
  logic      if_instr_valid;
  id_ex_t    id_ex;
  rf_write_t ex_write;

  // Primary branch or unusual state flushes the lane
  assign kill = pi_branch_taken_i || pi_unusual_kill_i;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  issue2_fetcher u_fetcher (
    .clk                  (clk),
    .reset_i              (reset_i),
    .di_en_i              (di_en_i),
    .pfb_i                (pfb_i),
    .pi_unusual_prevent_i (pi_unusual_prevent_i),
    .id_advance_i         (id_advance),
    .kill_i               (kill),
    .pfb_pop_o            (pfb_pop_o),
    .instr_o              (if_instr),
    .instr_valid_o        (if_instr_valid)
  );

  issue2_id_stage u_id_stage (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_i       (if_instr),
    .instr_valid_i (if_instr_valid),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .ex_fwd_i      (ex_write),        // Bypass path
    .ex_ready_i    (ex_ready),
    .pi_id_ready_i (pi_id_ready_i),
    .kill_i        (kill),
    .rf_read_o     (rf_read_o),
    .id_advance_o  (id_advance),
    .id_ex_o       (id_ex),
    .illegal_o     (i2_illegal_o)
  );

  issue2_ex_stage u_ex_stage (
    .id_ex_i       (id_ex),
    .pi_ex_ready_i (pi_ex_ready_i),
    .kill_i        (kill),
    .ex_ready_o    (ex_ready),
    .write_o       (ex_write)
  );

  assign rf_write_o = ex_write;  // Shared register file port

endmodule

`default_nettype wire

// File: tb_issue2.sv
// Issue2 lane testbench
`timescale 1ns/100ps
`default_nettype none

module tb_issue2 import issue2_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int N_RAND      = 24;   // Random ops after the operator sweep
  localparam int N_STALL     = 40;   // Ops under random back-pressure
  localparam int WORST_STALL = 4;    // Longest low period of a ready level
  localparam int N_INSTR     = 19 + 10 + N_RAND + 8 + N_STALL + 8 + 3 + 2;
  localparam int LIMIT_CYCLES = 10 + N_INSTR * (WORST_STALL + 3) + 200;

  logic      clk;
  logic      reset_i;
  logic      di_en_i;
  pfb_word_t pfb_i;
  logic      pfb_pop_o;
  rf_read_t  rf_read_o;
  xlen_t     rf_rdata_a_i;
  xlen_t     rf_rdata_b_i;
  rf_write_t rf_write_o;
  logic      pi_id_ready_i;
  logic      pi_ex_ready_i;
  logic      pi_branch_taken_i;
  logic      pi_unusual_kill_i;
  logic      pi_unusual_prevent_i;
  logic      i2_illegal_o;

  xlen_t       rf [32];             // Register file model
  xlen_t       shadow [32];         // Reference register state
  logic [31:0] pfb_word_q [$];      // Prefetch buffer contents
  int          pfb_idx_q [$];
  int          exp_idx_q [$];       // Predicted writes in order
  reg_addr_t   exp_addr_q [$];
  xlen_t       exp_data_q [$];
  int          pop_cycle [0:511];
  logic        popped [0:511];
  int          n_issued;
  int          cycle;
  int          mismatches;
  int          failures;
  int          illegal_cnt;
  int          wr_idx;
  int          stall_left;
  int          stall_sel;
  integer      seed;
  logic        timing_chk;
  logic        stall_en;
  logic        pop_s;
  logic        adv_s;
  logic        kill_s;
  logic        slot_full;         // Fetcher slot as the rules predict
  logic        wr_pend;
  reg_addr_t   wr_addr;
  xlen_t       wr_data;

  issue2 DUT (.*);

  assign rf_rdata_a_i = rf[rf_read_o.rs1_addr];  // Same-cycle read
  assign rf_rdata_b_i = rf[rf_read_o.rs2_addr];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("Timeout: the lane did not finish its instructions in %0d cycles", LIMIT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %08h expected %08h (cycle %0d)", name, got, exp, cycle);
      mismatches++;
    end
  endtask

  task automatic report(input string msg);
    $display("ERROR: %s (cycle %0d)", msg, cycle);
    failures++;
  endtask

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Encoding and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  // Ops 0..9 register form, 10..18 immediate form
  function automatic logic [31:0] make_op(input int k, input reg_addr_t rd, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [11:0] imm);
    case (k)
      0:  return enc_r(7'h00, rs2, rs1, 3'd0, rd);  // add
      1:  return enc_r(7'h20, rs2, rs1, 3'd0, rd);  // sub
      2:  return enc_r(7'h00, rs2, rs1, 3'd1, rd);
      3:  return enc_r(7'h00, rs2, rs1, 3'd2, rd);
      4:  return enc_r(7'h00, rs2, rs1, 3'd3, rd);
      5:  return enc_r(7'h00, rs2, rs1, 3'd4, rd);
      6:  return enc_r(7'h00, rs2, rs1, 3'd5, rd);  // srl
      7:  return enc_r(7'h20, rs2, rs1, 3'd5, rd);  // sra
      8:  return enc_r(7'h00, rs2, rs1, 3'd6, rd);
      9:  return enc_r(7'h00, rs2, rs1, 3'd7, rd);
      10: return enc_i(imm, rs1, 3'd0, rd);         // addi
      11: return enc_i(imm, rs1, 3'd2, rd);
      12: return enc_i(imm, rs1, 3'd3, rd);
      13: return enc_i(imm, rs1, 3'd4, rd);
      14: return enc_i(imm, rs1, 3'd6, rd);
      15: return enc_i(imm, rs1, 3'd7, rd);
      16: return enc_i({7'h00, imm[4:0]}, rs1, 3'd1, rd);  // slli
      17: return enc_i({7'h00, imm[4:0]}, rs1, 3'd5, rd);  // srli
      default: return enc_i({7'h20, imm[4:0]}, rs1, 3'd5, rd);  // srai
    endcase
  endfunction

  // Executes one word in program order and predicts its write
  task automatic execute_model(input logic [31:0] w, input int idx);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      r;
    logic       legal;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    rd  = w[11:7];
    a   = shadow[w[19:15]];
    if (opc == 7'h33) begin
      b     = shadow[w[24:20]];
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    end else begin
      b     = {{20{w[31]}}, w[31:20]};
      legal = (opc == 7'h13) && !(f3 == 3'd1 && f7 != 7'h00)
              && !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
    end
    case (f3)
      3'd0: r = (opc == 7'h33 && f7 == 7'h20) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (f7[5]) r = $signed(a) >>> b[4:0];  // Arithmetic
        else       r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    if (legal && rd != 5'd0) begin
      shadow[rd] = r;
      exp_idx_q.push_back(idx);
      exp_addr_q.push_back(rd);
      exp_data_q.push_back(r);
    end
  endtask

  task automatic issue_word(input logic [31:0] w, input bit modeled);
    pfb_word_q.push_back(w);
    pfb_idx_q.push_back(n_issued);
    popped[n_issued] = 1'b0;
    if (modeled) execute_model(w, n_issued);
    n_issued++;
  endtask

  task automatic wait_drain();
    while (pfb_word_q.size() != 0 || exp_idx_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors and drivers
  //////////////////////////////////////////////////////////////////////

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!reset_i) begin
      pop_s  = pfb_pop_o;
      adv_s  = pi_id_ready_i && pi_ex_ready_i;
      kill_s = pi_branch_taken_i || pi_unusual_kill_i;
      if (pfb_pop_o && pfb_idx_q.size() == 0) report("pop from an empty prefetch buffer");
      else if (pfb_pop_o) begin
        pop_cycle[pfb_idx_q[0]] = cycle;
        popped[pfb_idx_q[0]]    = 1'b1;
      end
      if (pfb_pop_o && slot_full && !adv_s) report("pop while ID is stalled");
      if (i2_illegal_o) illegal_cnt++;
      if (rf_write_o.we) begin
        if (exp_idx_q.size() == 0) report("register write with none expected");
        else begin
          wr_idx = exp_idx_q.pop_front();
          check("rf_write_o.waddr", 32'(rf_write_o.waddr), 32'(exp_addr_q.pop_front()));
          check("rf_write_o.wdata", rf_write_o.wdata, exp_data_q.pop_front());
          if (timing_chk) check("write cycle", cycle, pop_cycle[wr_idx] + 2);
        end
        wr_pend = 1'b1;
        wr_addr = rf_write_o.waddr;
        wr_data = rf_write_o.wdata;
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (wr_pend && wr_addr != 5'd0) rf[wr_addr] <= wr_data;  // Write at the edge
    wr_pend = 1'b0;
    if (reset_i || kill_s) slot_full = 1'b0;
    else if (pop_s)        slot_full = 1'b1;
    else if (adv_s)        slot_full = 1'b0;
    if (pop_s && pfb_word_q.size() != 0) begin
      void'(pfb_word_q.pop_front());
      void'(pfb_idx_q.pop_front());
    end
    pop_s = 1'b0;
    #2;
    pfb_i.valid = (pfb_word_q.size() != 0);
    pfb_i.word  = (pfb_word_q.size() != 0) ? pfb_word_q[0] : 32'h0;
    if (!stall_en) begin
      pi_id_ready_i = 1'b1;
      pi_ex_ready_i = 1'b1;
    end else if (stall_left > 0) begin
      pi_id_ready_i = (stall_sel == 1);  // 0 id low, 1 ex low, 2 both
      pi_ex_ready_i = (stall_sel == 0);
      stall_left--;
    end else begin
      pi_id_ready_i = 1'b1;
      pi_ex_ready_i = 1'b1;
      if (urand(3) == 0) begin
        stall_left = 1 + urand(WORST_STALL);
        stall_sel  = urand(3);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_all_ops();
    for (int k = 0; k < 19 + N_RAND; k++) begin
      issue_word(make_op(k % 19, 5'(5 + urand(27)), 5'(urand(32)), 5'(urand(32)),
                         12'(urand(4096))), 1'b1);
    end
    issue_word(make_op(16, 5'd5, 5'd3, 5'd0, 12'd31), 1'b1);     // slli by 31
    issue_word(make_op(16, 5'd6, 5'd3, 5'd0, 12'd0), 1'b1);      // slli by 0
    issue_word(make_op(18, 5'd7, 5'd1, 5'd0, 12'd31), 1'b1);     // srai sign fill
    issue_word(make_op(17, 5'd8, 5'd1, 5'd0, 12'd31), 1'b1);
    issue_word(make_op(7, 5'd9, 5'd1, 5'd3, 12'd0), 1'b1);       // sra by x3 low bits
    issue_word(make_op(6, 5'd10, 5'd1, 5'd3, 12'd0), 1'b1);
    issue_word(make_op(3, 5'd11, 5'd1, 5'd2, 12'd0), 1'b1);      // Signed min vs max
    issue_word(make_op(4, 5'd12, 5'd1, 5'd2, 12'd0), 1'b1);
    issue_word(make_op(11, 5'd13, 5'd1, 5'd0, 12'hfff), 1'b1);
    issue_word(make_op(12, 5'd14, 5'd2, 5'd0, 12'hfff), 1'b1);   // sltiu against all ones
    wait_drain();
  endtask

  task automatic test_forward_chain();
    timing_chk = 1'b1;
    issue_word(make_op(0, 5'd20, 5'd21, 5'd22, 12'd0), 1'b1);
    issue_word(make_op(10, 5'd20, 5'd20, 5'd0, 12'd5), 1'b1);
    issue_word(make_op(1, 5'd21, 5'd20, 5'd22, 12'd0), 1'b1);
    issue_word(make_op(5, 5'd20, 5'd21, 5'd20, 12'd0), 1'b1);
    issue_word(make_op(16, 5'd22, 5'd20, 5'd0, 12'd3), 1'b1);
    issue_word(make_op(8, 5'd23, 5'd22, 5'd20, 12'd0), 1'b1);
    issue_word(make_op(4, 5'd24, 5'd23, 5'd22, 12'd0), 1'b1);
    issue_word(make_op(9, 5'd20, 5'd24, 5'd23, 12'd0), 1'b1);
    wait_drain();
    timing_chk = 1'b0;
  endtask

  task automatic test_random_stall();
    stall_en = 1'b1;
    for (int k = 0; k < N_STALL; k++) begin
      issue_word(make_op(urand(19), 5'(1 + urand(31)), 5'(urand(32)), 5'(urand(32)),
                         12'(urand(4096))), 1'b1);
    end
    wait_drain();
    stall_en = 1'b0;
    repeat (WORST_STALL + 2) @(negedge clk);
  endtask

  task automatic test_kill(input bit use_branch);
    int idx_b;
    issue_word(make_op(0, 5'd25, 5'd1, 5'd2, 12'd0), 1'b0);      // Killed in EX
    idx_b = n_issued;
    issue_word(make_op(10, 5'd26, 5'd3, 5'd0, 12'd9), 1'b0);     // Killed in ID
    while (!popped[idx_b]) @(posedge clk);  // Set at the falling edge of its pop cycle
    #2;
    if (use_branch) pi_branch_taken_i = 1'b1;
    else            pi_unusual_kill_i = 1'b1;
    @(posedge clk);
    #2;
    pi_branch_taken_i = 1'b0;
    pi_unusual_kill_i = 1'b0;
    issue_word(make_op(1, 5'd25, 5'd2, 5'd3, 12'd0), 1'b1);
    issue_word(make_op(13, 5'd26, 5'd25, 5'd0, 12'h5a5), 1'b1);
    wait_drain();
  endtask

  task automatic test_illegal_rd0();
    int n0;
    n0 = illegal_cnt;
    issue_word(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd15), 1'b1);     // mul is not supported
    issue_word(make_op(0, 5'd0, 5'd1, 5'd2, 12'd0), 1'b1);       // Targets x0
    issue_word(make_op(10, 5'd15, 5'd0, 5'd0, 12'd7), 1'b1);
    wait_drain();
    check("i2_illegal_o pulses", 32'(illegal_cnt - n0), 32'd1);
  endtask

  task automatic test_fetch_block(input bit use_prevent);
    @(posedge clk);
    #2;
    if (use_prevent) pi_unusual_prevent_i = 1'b1;
    else             di_en_i = 1'b0;
    issue_word(make_op(10, 5'd16, 5'd16, 5'd0, 12'd1), 1'b1);
    repeat (8) begin
      @(negedge clk);
      check("pfb_pop_o", 32'(pfb_pop_o), 32'd0);
    end
    @(posedge clk);
    #2;
    pi_unusual_prevent_i = 1'b0;
    di_en_i = 1'b1;
    wait_drain();
  endtask

  initial begin
    seed = 32'hb2ad;
    {n_issued, cycle, mismatches, failures, illegal_cnt, stall_left, stall_sel} = '0;
    {timing_chk, stall_en, pop_s, adv_s, kill_s, slot_full, wr_pend} = '0;
    wr_addr = '0;
    wr_data = '0;
    reset_i = 1'b1;
    di_en_i = 1'b0;
    pfb_i = '0;
    pi_id_ready_i = 1'b1;
    pi_ex_ready_i = 1'b1;
    pi_branch_taken_i = 1'b0;
    pi_unusual_kill_i = 1'b0;
    pi_unusual_prevent_i = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = $random(seed);
    end
    shadow[0] = '0;
    shadow[1] = 32'h8000_0000;  // Edge operands for shifts and compares
    shadow[2] = 32'h7fff_ffff;
    shadow[3] = 32'hffff_ffff;
    for (int i = 0; i < 32; i++) begin
      rf[i] <= shadow[i];
    end
    repeat (10) @(posedge clk);
    #2;
    reset_i = 1'b0;
    di_en_i = 1'b1;
    @(negedge clk);
    check("pfb_pop_o", 32'(pfb_pop_o), 32'd0);
    check("rf_write_o.we", 32'(rf_write_o.we), 32'd0);
    check("i2_illegal_o", 32'(i2_illegal_o), 32'd0);
    test_all_ops();
    test_forward_chain();
    test_random_stall();
    test_kill(1'b1);
    test_kill(1'b0);
    test_illegal_rd0();
    test_fetch_block(1'b0);
    test_fetch_block(1'b1);
    if (exp_idx_q.size() != 0) report("predicted writes never arrived");
    $display("Done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
issue2_pkg.sv
issue2_alu.sv
issue2_decoder.sv
issue2_fetcher.sv
issue2_id_stage.sv
issue2_ex_stage.sv
issue2.sv
tb_issue2.sv

// File: run.sh
#!/bin/sh
# Build and run the issue2 lane testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f list.f --top-module tb_issue2 -o sim_issue2 > build.log 2>&1 \
  && ./obj_dir/sim_issue2 > sim.log 2>&1 \
  || { echo "Build or simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see sim.log"; exit 1; }
